// File: files.f
design/fetch_pkg.sv
design/br_redirect.sv
design/fetch_stage.sv
design/inst_sram.sv
design/decode_latch.sv
design/fetch_top.sv
verification/clock_gen.sv
verification/fetch_sva.sv
verification/fetch_tb.sv

// File: run.sh
#!/bin/sh
# build and run the fetch front-end simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f files.f \
    --top-module fetch_tb \
    -o fetch_sim

./obj_dir/fetch_sim | tee sim.log

grep -q "^Test OK$" sim.log

// File: verification/fetch_tb.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_tb
    import fetch_pkg::*;
();

    typedef enum logic [1:0] {
        ACT_NONE,
        ACT_REDIRECT,
        ACT_STALL
    } act_t;

    typedef struct packed {
        int unsigned wait_xfers;   // deliveries to wait before the action
        act_t        act;
        pc_t         target;
        int unsigned stall_len;
    } step_t;

    localparam int NUM_STEPS       = 14;
    localparam int DRAIN_XFERS     = 10;
    localparam int STALL_DRAIN_MAX = 2;   // latch plus one fetch in flight

    logic  clk;
    logic  reset;
    logic  br_valid;
    pc_t   br_target;
    logic  stall;
    logic  out_allowin;
    logic  out_valid;
    pc_t   out_pc;
    inst_t out_inst;

    step_t       steps [NUM_STEPS];
    int unsigned delivered = 0;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          timeout_limit = 0;
    int unsigned seed_draw;

    // monitor state
    pc_t   exp_pc = RESET_PC;
    logic  was_reset = 1'b0;
    logic  hold = 1'b0;
    pc_t   held_pc;
    inst_t held_inst;
    int    stall_xfers = 0;

    clock_gen clock_gen_inst (
        .clk   (clk),
        .reset (reset)
    );

    fetch_top fetch_top_inst (
        .clk         (clk),
        .reset       (reset),
        .br_valid    (br_valid),
        .br_target   (br_target),
        .stall       (stall),
        .out_allowin (out_allowin),
        .out_valid   (out_valid),
        .out_pc      (out_pc),
        .out_inst    (out_inst)
    );

    task automatic compare_value(input logic [31:0] actual, input logic [31:0] expected,
                                 input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic load_steps();
        steps[0]  = '{6,  ACT_NONE,     32'h0000_0000, 0};
        steps[1]  = '{4,  ACT_REDIRECT, 32'h1c00_0100, 0};
        steps[2]  = '{5,  ACT_REDIRECT, 32'h1c00_200c, 0};
        steps[3]  = '{0,  ACT_REDIRECT, 32'h1c00_3004, 0};  // back to back
        steps[4]  = '{0,  ACT_REDIRECT, 32'h1c00_4008, 0};  // this one wins
        steps[5]  = '{6,  ACT_STALL,    32'h0000_0000, 12};
        steps[6]  = '{3,  ACT_STALL,    32'h0000_0000, 1};
        steps[7]  = '{8,  ACT_REDIRECT, 32'h1c00_0ff8, 0};
        steps[8]  = '{1,  ACT_REDIRECT, 32'h1c00_5000, 0};
        steps[9]  = '{10, ACT_STALL,    32'h0000_0000, 20};
        steps[10] = '{2,  ACT_REDIRECT, 32'h1c00_6004, 0};
        steps[11] = '{0,  ACT_STALL,    32'h0000_0000, 6};  // stall on a pending redirect
        steps[12] = '{12, ACT_NONE,     32'h0000_0000, 0};
        steps[13] = '{5,  ACT_REDIRECT, 32'h1c00_000c, 0};
    endtask

    function automatic int compute_limit();
        int total_wait;
        int total_stall;
        total_wait  = DRAIN_XFERS;
        total_stall = 0;
        for (int k = 0; k < NUM_STEPS; k++) begin
            total_wait  += int'(steps[k].wait_xfers);
            total_stall += int'(steps[k].stall_len);
        end
        return total_wait * 6 + total_stall + 200;
    endfunction

    task automatic wait_deliveries(input int unsigned n);
        int unsigned start;
        start = delivered;
        while (delivered < start + n) @(posedge clk);
    endtask

    task automatic send_redirect(input pc_t target);
        br_valid  <= 1'b1;
        br_target <= target;
        @(posedge clk);
        br_valid  <= 1'b0;
    endtask

    task automatic hold_stall(input int unsigned len);
        stall <= 1'b1;
        repeat (len) @(posedge clk);
        stall <= 1'b0;
    endtask

    // consumer ready, high about 70 percent of cycles
    always @(posedge clk) begin
        out_allowin <= ($urandom % 100) < 70;
    end

    // output monitor and reference pc model
    always @(posedge clk) begin
        if (reset) begin
            if (was_reset) compare_value({31'b0, out_valid}, 32'd0, "out_valid during reset");
            hold        = 1'b0;
            stall_xfers = 0;
        end else begin
            if (hold && out_valid) begin
                compare_value(out_pc, held_pc, "out_pc under back-pressure");
                compare_value(out_inst, held_inst, "out_inst under back-pressure");
            end
            if (out_valid && out_allowin) begin
                compare_value(out_pc, exp_pc, "out_pc");
                compare_value(out_inst, exp_pc ^ INST_SALT, "out_inst");
                exp_pc    = exp_pc + 32'd4;
                delivered <= delivered + 1;
                if (stall) begin
                    stall_xfers++;
                    if (stall_xfers > STALL_DRAIN_MAX) begin
                        compare_value(stall_xfers, STALL_DRAIN_MAX, "words delivered in stall");
                    end
                end
            end
            if (!stall) stall_xfers = 0;
            if (br_valid) exp_pc = br_target;   // older words already checked above
            hold      = out_valid && !out_allowin;
            held_pc   = out_pc;
            held_inst = out_inst;
        end
        was_reset = reset;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (timeout_limit > 0 && cycles >= timeout_limit) begin
            $display("Timeout: run stopped after %0d cycles, stimulus did not complete", cycles);
            $display("checks %0d, errors %0d", checks, errors);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        seed_draw   = $urandom(35338);
        br_valid    = 1'b0;
        br_target   = '0;
        stall       = 1'b0;
        out_allowin = 1'b0;
        load_steps();
        timeout_limit = compute_limit();

        @(posedge clk);
        while (reset) @(posedge clk);

        for (int i = 0; i < NUM_STEPS; i++) begin
            wait_deliveries(steps[i].wait_xfers);
            case (steps[i].act)
                ACT_REDIRECT: send_redirect(steps[i].target);
                ACT_STALL:    hold_stall(steps[i].stall_len);
                default:      ;
            endcase
        end
        wait_deliveries(DRAIN_XFERS);   // sequence resumes after the last action
        @(posedge clk);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/fetch_sva.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_sva
    import fetch_pkg::*;
(
    input wire logic clk,
    input wire logic reset,
    input wire logic stall,
    input wire logic flush,
    input wire pc_t  redir_target,
    input wire logic inst_req,
    input wire pc_t  inst_addr,
    input wire logic inst_addr_ok,
    input wire logic fs_to_ds_valid
);

    logic wait_target_q;   // flush seen, target not yet accepted

    always_ff @(posedge clk) begin
        if (reset) begin
            wait_target_q <= 1'b0;
        end else if (inst_req && inst_addr_ok) begin
            wait_target_q <= 1'b0;
        end else if (flush) begin
            wait_target_q <= 1'b1;
        end
    end

    // no new address goes out while stalled
    stall_blocks_req: assert property (@(posedge clk) disable iff (reset)
        stall |-> !inst_req)
        else $error("inst_req high while stall is high");

    // request held until the memory takes it
    addr_held: assert property (@(posedge clk) disable iff (reset)
        inst_req && !inst_addr_ok |=> $stable(inst_addr))
        else $error("inst_addr changed before inst_addr_ok");

    no_valid_after_reset: assert property (@(posedge clk)
        reset |=> !fs_to_ds_valid)
        else $error("fs_to_ds_valid high right after reset");

    // from flush until the target is accepted, only the target is requested
    target_first: assert property (@(posedge clk) disable iff (reset)
        (flush || wait_target_q) && inst_req |-> inst_addr == redir_target)
        else $error("request after flush does not carry the redirect target");

endmodule

bind fetch_stage fetch_sva fetch_sva_inst (
    .clk            (clk),
    .reset          (reset),
    .stall          (stall),
    .flush          (flush),
    .redir_target   (redir_target),
    .inst_req       (inst_req),
    .inst_addr      (inst_addr),
    .inst_addr_ok   (inst_addr_ok),
    .fs_to_ds_valid (fs_to_ds_valid)
);

`default_nettype wire

// File: verification/clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module clock_gen (
    output logic clk,
    output logic reset
);

    localparam int HALF_PERIOD = 4;   // 8 ns clock
    localparam int RESET_CYCLES = 3;

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

    always #(HALF_PERIOD) clk = ~clk;

endmodule

`default_nettype wire

// File: design/fetch_top.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_top
    import fetch_pkg::*;
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic br_valid,
    input  wire pc_t  br_target,
    input  wire logic stall,
    input  wire logic out_allowin,
    output logic      out_valid,
    output pc_t       out_pc,
    output inst_t     out_inst
);

    // redirect path
    logic  redir_pending;
    pc_t   redir_target;
    logic  redir_taken;
    logic  flush;

    // instruction memory bus
    logic  inst_req;
    pc_t   inst_addr;
    logic  inst_addr_ok;
    logic  inst_data_ok;
    inst_t inst_rdata;

    // fetch to decode
    logic  fs_to_ds_valid;
    pc_t   fs_pc;
    inst_t fs_inst;
    logic  ds_allowin;

    br_redirect br_redirect_inst (
        .clk           (clk),
        .reset         (reset),
        .br_valid      (br_valid),
        .br_target     (br_target),
        .redir_taken   (redir_taken),
        .redir_pending (redir_pending),
        .redir_target  (redir_target),
        .flush         (flush)
    );

    fetch_stage fetch_stage_inst (
        .clk            (clk),
        .reset          (reset),
        .stall          (stall),
        .flush          (flush),
        .redir_pending  (redir_pending),
        .redir_target   (redir_target),
        .redir_taken    (redir_taken),
        .inst_req       (inst_req),
        .inst_addr      (inst_addr),
        .inst_addr_ok   (inst_addr_ok),
        .inst_data_ok   (inst_data_ok),
        .inst_rdata     (inst_rdata),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_pc          (fs_pc),
        .fs_inst        (fs_inst),
        .ds_allowin     (ds_allowin)
    );

    inst_sram inst_sram_inst (
        .clk          (clk),
        .reset        (reset),
        .inst_req     (inst_req),
        .inst_addr    (inst_addr),
        .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok),
        .inst_rdata   (inst_rdata)
    );

    decode_latch decode_latch_inst (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_pc          (fs_pc),
        .fs_inst        (fs_inst),
        .ds_allowin     (ds_allowin),
        .out_valid      (out_valid),
        .out_pc         (out_pc),
        .out_inst       (out_inst),
        .out_allowin    (out_allowin)
    );

endmodule

`default_nettype wire

// File: design/decode_latch.sv
`timescale 1ns/1ns
`default_nettype none

module decode_latch
    import fetch_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire logic  flush,
    input  wire logic  fs_to_ds_valid,
    input  wire pc_t   fs_pc,
    input  wire inst_t fs_inst,
    output logic       ds_allowin,
    output logic       out_valid,
    output pc_t        out_pc,
    output inst_t      out_inst,
    input  wire logic  out_allowin
);

    logic valid_q;
    logic load;

    // a word older than the redirect never leaves in the flush cycle
    assign out_valid = valid_q && !flush;

    // empty, or the held word leaves this cycle
    assign ds_allowin = !out_valid || out_allowin;

    assign load = fs_to_ds_valid && ds_allowin && !flush;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (flush) begin
            valid_q <= 1'b0;        // flush wins over a load
        end else if (ds_allowin) begin
            valid_q <= fs_to_ds_valid;
        end
    end

    // pair register
    always_ff @(posedge clk) begin
        if (load) begin
            out_pc   <= fs_pc;
            out_inst <= fs_inst;
        end
    end

endmodule

`default_nettype wire

// File: design/inst_sram.sv
`timescale 1ns/1ns
`default_nettype none

module inst_sram
    import fetch_pkg::*;
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic inst_req,
    input  wire pc_t  inst_addr,
    output logic      inst_addr_ok,
    output logic      inst_data_ok,
    output inst_t     inst_rdata
);

    mem_state_t state_q;
    lat_cnt_t   cnt_q;     // cycles left before data_ok
    pc_t        addr_q;
    logic       accept;

    assign inst_addr_ok = (state_q == IDLE);
    assign accept       = inst_req && inst_addr_ok;

    // data_ok on the last busy cycle
    assign inst_data_ok = (state_q == BUSY) && (cnt_q == '0);

    // contents computed from the address
    assign inst_rdata = addr_q ^ INST_SALT;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (accept) begin
                        state_q <= BUSY;
                        // latency is LAT_BASE plus addr[3:2]
                        cnt_q   <= lat_cnt_t'(LAT_BASE - 1) + {1'b0, inst_addr[3:2]};
                    end
                end
                BUSY: begin
                    if (cnt_q == '0) begin
                        state_q <= IDLE;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= inst_addr;
        end
    end

endmodule

`default_nettype wire

// File: design/fetch_stage.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_stage
    import fetch_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire logic  stall,
    input  wire logic  flush,
    input  wire logic  redir_pending,
    input  wire pc_t   redir_target,
    output logic       redir_taken,
    output logic       inst_req,
    output pc_t        inst_addr,
    input  wire logic  inst_addr_ok,
    input  wire logic  inst_data_ok,
    input  wire inst_t inst_rdata,
    output logic       fs_to_ds_valid,
    output pc_t        fs_pc,
    output inst_t      fs_inst,
    input  wire logic  ds_allowin
);

    pc_t   pc_q;          // address of the fetch in flight or buffered
    pc_t   next_pc;
    logic  run_q;         // request enable, comes up one cycle out of reset
    logic  busy_q;        // accepted, waiting for data_ok
    logic  cancel_q;      // in-flight fetch was hit by flush
    logic  buf_valid_q;
    inst_t buf_inst_q;
    logic  fs_allowin;
    logic  req_fire;
    logic  rsp_ok;

    // pre-IF: next pc select
    assign next_pc = redir_pending ? redir_target : pc_q + PC_STEP;

    // room for a new word once nothing is outstanding and the buffer
    // is empty, draining this cycle or being dropped by flush
    assign fs_allowin = run_q && !busy_q && (!buf_valid_q || ds_allowin || flush);

    assign inst_req    = fs_allowin && !stall;
    assign inst_addr   = next_pc;
    assign req_fire    = inst_req && inst_addr_ok;
    assign redir_taken = req_fire && redir_pending;

    // usable response this cycle
    assign rsp_ok = inst_data_ok && busy_q && !cancel_q && !flush;

    assign fs_to_ds_valid = (buf_valid_q || rsp_ok) && !flush;
    assign fs_pc          = pc_q;
    assign fs_inst        = buf_valid_q ? buf_inst_q : inst_rdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
        end
    end

    // pc register, preset one step below the reset vector
    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= RESET_PC - PC_STEP;
        end else if (req_fire) begin
            pc_q <= next_pc;
        end
    end

    // one outstanding fetch at most
    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q <= 1'b0;
        end else if (req_fire) begin
            busy_q <= 1'b1;
        end else if (inst_data_ok) begin
            busy_q <= 1'b0;
        end
    end

    // a data_ok in the flush cycle itself is dropped through rsp_ok
    always_ff @(posedge clk) begin
        if (reset) begin
            cancel_q <= 1'b0;
        end else if (inst_data_ok) begin
            cancel_q <= 1'b0;
        end else if (flush && busy_q) begin
            cancel_q <= 1'b1;
        end
    end

    // word returned under back-pressure
    always_ff @(posedge clk) begin
        if (reset) begin
            buf_valid_q <= 1'b0;
        end else if (flush) begin
            buf_valid_q <= 1'b0;
        end else if (buf_valid_q && ds_allowin) begin
            buf_valid_q <= 1'b0;     // handed to decode
        end else if (rsp_ok && !ds_allowin) begin
            buf_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_ok && !ds_allowin) begin
            buf_inst_q <= inst_rdata;
        end
    end

endmodule

`default_nettype wire

// File: design/br_redirect.sv
`timescale 1ns/1ns
`default_nettype none

module br_redirect
    import fetch_pkg::*;
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic br_valid,
    input  wire pc_t  br_target,
    input  wire logic redir_taken,
    output logic      redir_pending,
    output pc_t       redir_target,
    output logic      flush
);

    // pending flag and flush pulse
    always_ff @(posedge clk) begin
        if (reset) begin
            redir_pending <= 1'b0;
            flush         <= 1'b0;
        end else begin
            flush <= br_valid;     // one cycle behind the strobe
            if (br_valid) begin
                redir_pending <= 1'b1;  // a new strobe beats a take in the same cycle
            end else if (redir_taken) begin
                redir_pending <= 1'b0;
            end
        end
    end

    // newest target wins
    always_ff @(posedge clk) begin
        if (br_valid) begin
            redir_target <= br_target;
        end
    end

endmodule

`default_nettype wire

// File: design/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // instruction byte address
    typedef logic [31:0] pc_t;

    // raw instruction word
    typedef logic [31:0] inst_t;

    // memory latency down-counter, covers up to LAT_BASE + 3
    typedef logic [2:0] lat_cnt_t;

    // first fetch address after reset
    localparam pc_t RESET_PC = 32'h1c00_0000;

    // sequential fetch step
    localparam pc_t PC_STEP = 32'h0000_0004;

    // memory contents are addr ^ INST_SALT
    localparam inst_t INST_SALT = 32'h9e37_79b9;

    // minimum cycles from address acceptance to data_ok
    localparam int unsigned LAT_BASE = 1;

    // instruction memory model states
    typedef enum logic {
        IDLE,
        BUSY
    } mem_state_t;

endpackage

`default_nettype wire
